/* verilog/cpuPkg.sv */
package cpuPkg;

  localparam int regIdWidth = 4; // Sixteen architectural registers

  //////////////////////////////
  // Opcodes
  //////////////////////////////
  typedef enum logic [3:0] {
    ADD    = 4'h0,
    SUB    = 4'h1,
    XOR    = 4'h2,
    RED    = 4'h3,
    SLL    = 4'h4,
    SRA    = 4'h5,
    ROR    = 4'h6,
    PADDSB = 4'h7,
    LW     = 4'h8,
    SW     = 4'h9,
    LLB    = 4'hA,
    LHB    = 4'hB,
    B      = 4'hC,
    BR     = 4'hD,
    PCS    = 4'hE,
    HLT    = 4'hF
  } opcodeT;

  //////////////////////////////
  // Instruction word views
  //////////////////////////////
  typedef struct packed {
    opcodeT                opcode;
    logic [regIdWidth-1:0] rd;     // Dest, also LLB/LHB target
    logic [regIdWidth-1:0] rs;     // Source 1, BR base register
    logic [regIdWidth-1:0] rt;     // Source 2 or shift amount
  } rFmtT;

  typedef struct packed {
    opcodeT                opcode;
    logic [regIdWidth-1:0] rt;     // LW dest / SW data
    logic [regIdWidth-1:0] rs;     // Address base
    logic [3:0]            offset; // Word offset
  } memFmtT;

  typedef struct packed {
    opcodeT     opcode;
    logic [2:0] cond;              // Flag condition code
    logic [8:0] label;             // PC-relative target
  } brFmtT;

  // Same 16 bits, picked apart by opcode
  typedef union packed {
    rFmtT   rFmt;
    memFmtT memFmt;
    brFmtT  brFmt;
  } instrWordT;

  //////////////////////////////
  // Flag-setting sets
  //////////////////////////////
  // Z: ADD SUB XOR SLL SRA ROR
  // N and V: ADD SUB only
  // RED and PADDSB leave the flags alone
  function automatic logic setsZ(opcodeT op);
    return op inside {ADD, SUB, XOR, SLL, SRA, ROR};
  endfunction

  function automatic logic setsNv(opcodeT op);
    return op inside {ADD, SUB};
  endfunction

endpackage

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import cpuPkg::*; (
  input  instrWordT             instr,     // Raw decode-stage word
  output logic [regIdWidth-1:0] srcReg1,   // First read port ID
  output logic [regIdWidth-1:0] srcReg2,   // Second read port ID
  output logic [regIdWidth-1:0] dstReg,    // Write-back ID
  output logic                  regWrite,  // Writes the register file
  output logic                  memEnable, // Touches data memory
  output logic                  memWrite,  // Store
  output logic                  zEn,       // Updates Z
  output logic                  nvEn,      // Updates N and V
  output logic                  branch,    // B or BR
  output logic                  brReg,     // BR only
  output logic                  halt       // HLT
);

  opcodeT op;

  // Opcode sits in bits 15:12 in every view
  assign op = instr.rFmt.opcode;

  //////////////////////////////
  // Register IDs and controls
  //////////////////////////////
  always_comb begin
    // Everything idle unless the opcode says otherwise
    srcReg1   = '0;
    srcReg2   = '0;
    dstReg    = '0;
    regWrite  = 1'b0;
    memEnable = 1'b0;
    memWrite  = 1'b0;
    branch    = 1'b0;
    brReg     = 1'b0;
    halt      = 1'b0;

    case (op)
      ADD, SUB, XOR, RED, SLL, SRA, ROR, PADDSB: begin
        srcReg1  = instr.rFmt.rs;
        srcReg2  = instr.rFmt.rt;     // Immediate for shifts, still compared
        dstReg   = instr.rFmt.rd;
        regWrite = 1'b1;
      end
      LW: begin
        srcReg1   = instr.memFmt.rs;  // Address base
        dstReg    = instr.memFmt.rt;  // Loaded value lands here
        regWrite  = 1'b1;
        memEnable = 1'b1;
      end
      SW: begin
        srcReg1   = instr.memFmt.rs;  // Address base
        srcReg2   = instr.memFmt.rt;  // Store data, bits 11:8
        memEnable = 1'b1;
        memWrite  = 1'b1;
      end
      LLB, LHB: begin
        // Read-modify-write of one byte
        srcReg1  = instr.rFmt.rd;
        dstReg   = instr.rFmt.rd;
        regWrite = 1'b1;
      end
      B: begin
        branch = 1'b1;                // Condition only, no register read
      end
      BR: begin
        srcReg1 = instr.rFmt.rs;      // Base register holds the target
        branch  = 1'b1;
        brReg   = 1'b1;
      end
      PCS: begin
        dstReg   = instr.rFmt.rd;     // Saves PC+2
        regWrite = 1'b1;
      end
      HLT: begin
        halt = 1'b1;
      end
    endcase
  end

  //////////////////////////////
  // Flag enables
  //////////////////////////////
  assign zEn  = setsZ(op);
  assign nvEn = setsNv(op);

endmodule

/* verilog/pipeCtrlRegs.sv */
`timescale 1ns/1ps

module pipeCtrlRegs import cpuPkg::*; (
  input  logic                  clk,
  input  logic                  rstN,          // Sync, active low
  input  logic                  idFlush,       // Load a bubble into ID/EX
  input  logic                  regWrite,      // Decoded fields from ID
  input  logic                  memEnable,
  input  logic                  memWrite,
  input  logic                  zEn,
  input  logic                  nvEn,
  input  logic [regIdWidth-1:0] dstReg,
  output logic                  idExRegWrite,  // Fields of the EX instruction
  output logic                  idExMemEnable,
  output logic                  idExMemWrite,
  output logic                  idExZEn,
  output logic                  idExNvEn,
  output logic                  exMemRegWrite, // Fields of the MEM instruction
  output logic [regIdWidth-1:0] idExRd,
  output logic [regIdWidth-1:0] exMemRd
);

  //////////////////////////////
  // ID/EX control
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      // Bubble with nothing written and no memory or flags
      idExRegWrite  <= 1'b0;
      idExMemEnable <= 1'b0;
      idExMemWrite  <= 1'b0;
      idExZEn       <= 1'b0;
      idExNvEn      <= 1'b0;
    end else if (idFlush) begin
      // Hazard in ID sends a NOP to EX
      idExRegWrite  <= 1'b0;
      idExMemEnable <= 1'b0;
      idExMemWrite  <= 1'b0;
      idExZEn       <= 1'b0;
      idExNvEn      <= 1'b0;
    end else begin
      idExRegWrite  <= regWrite;
      idExMemEnable <= memEnable;
      idExMemWrite  <= memWrite;
      idExZEn       <= zEn;
      idExNvEn      <= nvEn;
    end
  end

  // Destination of the EX instruction
  always_ff @(posedge clk) begin
    idExRd <= dstReg;
  end

  //////////////////////////////
  // EX/MEM control
  //////////////////////////////
  // Never stalled so it always advances from ID/EX
  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMemRegWrite <= 1'b0;
    end else begin
      exMemRegWrite <= idExRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    exMemRd <= idExRd;                // Travels with exMemRegWrite
  end

  // A store in EX touches memory and writes no register
  assert property (@(posedge clk) disable iff (!rstN)
                   idExMemWrite |-> idExMemEnable && !idExRegWrite)
    else $error("ID/EX store fields inconsistent");

endmodule

/* verilog/hazardDetectionUnit.sv */
`timescale 1ns/1ps

module hazardDetectionUnit import cpuPkg::*; (
  input  logic                  clk,           // Assertions only
  input  logic                  rstN,          // Assertions only
  input  logic [regIdWidth-1:0] srcReg1,       // Rs in ID
  input  logic [regIdWidth-1:0] srcReg2,       // Rt in ID
  input  logic [regIdWidth-1:0] idExRd,        // Dest in EX
  input  logic [regIdWidth-1:0] exMemRd,       // Dest in MEM
  input  logic                  idExRegWrite,
  input  logic                  exMemRegWrite,
  input  logic                  idExMemEnable,
  input  logic                  idExMemWrite,
  input  logic                  memWrite,      // ID instruction is a store
  input  logic                  idExZEn,
  input  logic                  idExNvEn,
  input  logic                  branch,        // B or BR in ID
  input  logic                  brReg,         // BR in ID
  input  logic                  updatePc,      // Wrong path fetched
  input  logic                  halt,          // HLT in ID
  output logic                  pcStall,
  output logic                  ifIdStall,
  output logic                  idFlush,
  output logic                  ifFlush
);

  logic idExMemRead;   // LW in EX
  logic loadUseHazard;
  logic flagsBusy;     // Flag setter in EX
  logic bHazard;
  logic exBrHazard;    // EX writes the BR base
  logic memBrHazard;   // MEM writes the BR base
  logic brHazard;

  //////////////////////////////
  // Load-to-use
  //////////////////////////////
  assign idExMemRead = idExMemEnable & ~idExMemWrite;

  // Store data in Rt is covered by MEM-to-MEM forwarding
  assign loadUseHazard = idExMemRead & (idExRd != '0) &
                         ((idExRd == srcReg1) | ((idExRd == srcReg2) & ~memWrite));

  //////////////////////////////
  // Branches
  //////////////////////////////
  assign flagsBusy = idExZEn | idExNvEn;
  assign bHazard   = branch & flagsBusy; // Flags not settled yet

  assign exBrHazard  = idExRegWrite & (idExRd != '0) & (idExRd == srcReg1);
  assign memBrHazard = exMemRegWrite & (exMemRd != '0) & (exMemRd == srcReg1);

  // BR also waits for its base register to be written back
  assign brHazard = branch & brReg & (flagsBusy | exBrHazard | memBrHazard);

  //////////////////////////////
  // Stall and flush
  //////////////////////////////
  assign ifIdStall = halt | loadUseHazard | bHazard | brHazard;
  assign pcStall   = ifIdStall;                          // PC and IF/ID freeze together
  assign idFlush   = loadUseHazard | bHazard | brHazard; // Bubble into EX
  assign ifFlush   = updatePc;                           // Drop the wrong-path word

  // The bubble sent into EX clears every hazard that comes from EX
  assert property (@(posedge clk) disable iff (!rstN)
                   idFlush |=> !(loadUseHazard | bHazard | exBrHazard))
    else $error("EX hazard still present after a bubble");

  // A BR base hazard lasts two cycles at most
  assert property (@(posedge clk) disable iff (!rstN)
                   brHazard ##1 brHazard |=> !brHazard)
    else $error("BR stall longer than two cycles");

endmodule

/* verilog/hazardCtrlTop.sv */
`timescale 1ns/1ps

module hazardCtrlTop import cpuPkg::*; (
  input  logic      clk,
  input  logic      rstN,      // Sync, active low
  input  logic      updatePc,  // Taken branch, refetch
  input  instrWordT instr,     // Word in decode, held while stalled
  output logic      pcStall,
  output logic      ifIdStall,
  output logic      idFlush,
  output logic      ifFlush
);

  // Decode-stage fields
  logic [regIdWidth-1:0] srcReg1;
  logic [regIdWidth-1:0] srcReg2;
  logic [regIdWidth-1:0] dstReg;
  logic                  regWrite;
  logic                  memEnable;
  logic                  memWrite;
  logic                  zEn;
  logic                  nvEn;
  logic                  branch;
  logic                  brReg;
  logic                  halt;

  // EX and MEM stage fields
  logic [regIdWidth-1:0] idExRd;
  logic [regIdWidth-1:0] exMemRd;
  logic                  idExRegWrite;
  logic                  idExMemEnable;
  logic                  idExMemWrite;
  logic                  idExZEn;
  logic                  idExNvEn;
  logic                  exMemRegWrite;

  //////////////////////////////
  // Decode
  //////////////////////////////
  instrDecoder instrDecoder_inst (
    .instr(instr), .srcReg1(srcReg1), .srcReg2(srcReg2), .dstReg(dstReg),
    .regWrite(regWrite), .memEnable(memEnable), .memWrite(memWrite),
    .zEn(zEn), .nvEn(nvEn), .branch(branch), .brReg(brReg), .halt(halt)
  );

  // ID/EX and EX/MEM shadows
  pipeCtrlRegs pipeCtrlRegs_inst (
    .clk(clk), .rstN(rstN), .idFlush(idFlush),
    .regWrite(regWrite), .memEnable(memEnable), .memWrite(memWrite),
    .zEn(zEn), .nvEn(nvEn), .dstReg(dstReg),
    .idExRegWrite(idExRegWrite), .idExMemEnable(idExMemEnable),
    .idExMemWrite(idExMemWrite), .idExZEn(idExZEn), .idExNvEn(idExNvEn),
    .exMemRegWrite(exMemRegWrite), .idExRd(idExRd), .exMemRd(exMemRd)
  );

  //////////////////////////////
  // Stall and flush
  //////////////////////////////
  hazardDetectionUnit hazardDetectionUnit_inst (
    .clk(clk), .rstN(rstN), .srcReg1(srcReg1), .srcReg2(srcReg2),
    .idExRd(idExRd), .exMemRd(exMemRd), .idExRegWrite(idExRegWrite),
    .exMemRegWrite(exMemRegWrite), .idExMemEnable(idExMemEnable),
    .idExMemWrite(idExMemWrite), .memWrite(memWrite), .idExZEn(idExZEn),
    .idExNvEn(idExNvEn), .branch(branch), .brReg(brReg), .updatePc(updatePc),
    .halt(halt), .pcStall(pcStall), .ifIdStall(ifIdStall), .idFlush(idFlush),
    .ifFlush(ifFlush)
  );

endmodule

/* verif/hazardModel.svh */
`ifndef hazardModelSvh
`define hazardModelSvh

// Decode-stage fields as the ISA tables define them
typedef struct packed {
  logic [regIdWidth-1:0] src1;
  logic [regIdWidth-1:0] src2;
  logic [regIdWidth-1:0] dst;   // Bits 11:8 in both rFmt and memFmt
  logic                  regWrite;
  logic                  memRead;
  logic                  memWrite;
  logic                  zEn;
  logic                  nvEn;
  logic                  branch;
  logic                  brReg;
  logic                  halt;
} decodedT;

// Shadow of the instructions in EX and MEM
decodedT               exStage     = '0;
logic                  memRegWrite = 1'b0;
logic [regIdWidth-1:0] memRd       = '0;

function automatic decodedT decodeRef(instrWordT w);
  decodedT d;
  opcodeT  op;
  logic    isAlu;
  logic    isByte;
  op     = w.rFmt.opcode;
  isAlu  = (op <= PADDSB);                // Opcodes 0 to 7
  isByte = (op == LLB) || (op == LHB);    // Read-modify of rd
  d      = '0;
  d.src1 = (isAlu || op == LW || op == SW || op == BR) ? w.memFmt.rs :
           (isByte ? w.rFmt.rd : '0);
  d.src2     = isAlu ? w.rFmt.rt : ((op == SW) ? w.memFmt.rt : '0);
  d.dst      = w.rFmt.rd;
  d.regWrite = isAlu || isByte || op == LW || op == PCS;
  d.memRead  = (op == LW);
  d.memWrite = (op == SW);
  d.zEn      = op inside {ADD, SUB, XOR, SLL, SRA, ROR};
  d.nvEn     = op inside {ADD, SUB};
  d.branch   = (op == B) || (op == BR);
  d.brReg    = (op == BR);
  d.halt     = (op == HLT);
  return d;
endfunction

// Expected {pcStall, ifIdStall, idFlush, ifFlush} for the word in ID
function automatic logic [3:0] expectOutputs(instrWordT w, logic upd);
  decodedT d;
  logic    loadUse;
  logic    bStall;
  logic    brStall;
  logic    hazard;
  logic    stall;
  d       = decodeRef(w);
  // Store data is forwarded MEM to MEM, so src2 of a store is exempt
  loadUse = exStage.memRead && (exStage.dst != '0) &&
            (exStage.dst == d.src1 || (exStage.dst == d.src2 && !d.memWrite));
  bStall  = d.branch && (exStage.zEn || exStage.nvEn); // Flags still in flight
  brStall = d.brReg &&
            ((exStage.regWrite && exStage.dst != '0 && exStage.dst == d.src1) ||
             (memRegWrite && memRd != '0 && memRd == d.src1));
  hazard  = loadUse || bStall || brStall;
  stall   = hazard || d.halt;
  return {stall, stall, hazard, upd};
endfunction

// Edge rule of the ID/EX and EX/MEM registers
task automatic advanceShadow(input logic rst, input instrWordT w, input logic upd);
  logic [3:0] exp;
  exp = expectOutputs(w, upd);
  if (!rst) begin
    exStage     = '0;
    memRegWrite = 1'b0;
  end else begin
    memRegWrite = exStage.regWrite;       // EX/MEM always advances
    memRd       = exStage.dst;
    if (exp[1]) begin
      exStage = '0;                       // Bubble
    end else begin
      exStage = decodeRef(w);
    end
  end
endtask

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrStep(logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

/* verif/hazardCtrlTb.sv */
`timescale 1ns/1ps

module hazardCtrlTb import cpuPkg::*; ();

  localparam int resetCycles    = 5;
  localparam int directedBudget = 200;  // Upper bound for the directed groups
  localparam int randomCycles   = 2000; // Halt-free stream
  localparam int finalCycles    = 300;  // HLT may show up here
  localparam int haltCycles     = 12;
  localparam int watchdogNs     = (resetCycles + directedBudget + randomCycles +
                                   finalCycles + haltCycles) * 8 + 400;

  logic        clk = 1'b0;
  logic        rstN;
  logic        updatePc;
  instrWordT   instr;
  logic        pcStall;
  logic        ifIdStall;
  logic        idFlush;
  logic        ifFlush;
  logic [31:0] lfsrState = 32'h7451f705;
  logic        lastStall = 1'b0;        // Expected stall of the cycle just ended
  logic [3:0]  expOut;
  int          stallCount = 0;          // Cycles seen with each output high
  int          flushCount = 0;
  int          fetchFlushCount = 0;
  int          stallMark;
  int          flushMark;
  int          fetchFlushMark;

  `include "hazardModel.svh"

  localparam instrWordT nopWord = 16'h3000; // RED r0 r0 r0 sets no flags

  hazardCtrlTop hazardCtrlTop_inst (
    .clk(clk), .rstN(rstN), .updatePc(updatePc), .instr(instr),
    .pcStall(pcStall), .ifIdStall(ifIdStall), .idFlush(idFlush), .ifFlush(ifFlush)
  );

  always #4 clk = ~clk;                 // 8 ns period

  //////////////////////////////
  // Model and compare
  //////////////////////////////
  always @(posedge clk) advanceShadow(rstN, instr, updatePc);

  always @(posedge clk) begin
    #7;                                 // Just before the next edge
    if (rstN) begin
      expOut = expectOutputs(instr, updatePc);
      checkValue("pcStall", 32'(pcStall), 32'(expOut[3]));
      checkValue("ifIdStall", 32'(ifIdStall), 32'(expOut[2]));
      checkValue("idFlush", 32'(idFlush), 32'(expOut[1]));
      checkValue("ifFlush", 32'(ifFlush), 32'(expOut[0]));
      lastStall = expOut[2];
      if (ifIdStall) stallCount++;
      if (idFlush) flushCount++;
      if (ifFlush) fetchFlushCount++;
    end
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      failRun($sformatf("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  //////////////////////////////
  // Instruction words
  //////////////////////////////
  function automatic instrWordT rWord(opcodeT op, int rd, int rs, int rt);
    instrWordT w;
    w.rFmt.opcode = op;
    w.rFmt.rd     = 4'(rd);
    w.rFmt.rs     = 4'(rs);             // BR base sits here too
    w.rFmt.rt     = 4'(rt);
    return w;
  endfunction

  function automatic instrWordT memWord(opcodeT op, int rt, int rs);
    instrWordT w;
    w.memFmt.opcode = op;
    w.memFmt.rt     = 4'(rt);           // LW dest or SW data
    w.memFmt.rs     = 4'(rs);
    w.memFmt.offset = 4'h2;
    return w;
  endfunction

  function automatic instrWordT branchWord();
    instrWordT w;
    w.brFmt.opcode = B;
    w.brFmt.cond   = 3'b001;
    w.brFmt.label  = 9'h010;
    return w;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] randBits(int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsrState = lfsrStep(lfsrState);
      val       = {val[30:0], lfsrState[0]};
    end
    return val;
  endfunction

  // Weighted toward LW, B, BR and ALU ops over registers r0 to r7
  function automatic instrWordT randomWord(logic allowHalt);
    logic [3:0] sel;
    opcodeT     op;
    instrWordT  w;
    sel = 4'(randBits(4));
    case (sel)
      4'd0, 4'd1, 4'd2, 4'd3: op = LW;
      4'd4, 4'd5:             op = B;
      4'd6, 4'd7:             op = BR;
      4'd8, 4'd9, 4'd10, 4'd11: op = opcodeT'({1'b0, 3'(randBits(3))});
      4'd12:                  op = SW;
      4'd13:                  op = LLB;
      4'd14:                  op = PCS;
      default:                op = allowHalt ? HLT : SUB;
    endcase
    w.rFmt.opcode = op;
    w.rFmt.rd     = {1'b0, 3'(randBits(3))};
    w.rFmt.rs     = {1'b0, 3'(randBits(3))};
    w.rFmt.rt     = {1'b0, 3'(randBits(3))};
    return w;
  endfunction

  //////////////////////////////
  // Fetch side
  //////////////////////////////
  // Waits out a stall with the held word and then presents the next one
  task automatic sendInstr(input instrWordT w, input logic upd);
    @(posedge clk);
    #1;
    while (lastStall) begin
      updatePc = 1'b0;
      @(posedge clk);
      #1;
    end
    instr    = w;
    updatePc = upd;
  endtask

  task automatic drainPipe();
    sendInstr(nopWord, 1'b0);
    sendInstr(nopWord, 1'b0);
  endtask

  // Every directed stall here is a hazard so idFlush counts the same
  task automatic runPair(input string what, input instrWordT first, input int gap,
                         input instrWordT second, input int stalls, input logic upd);
    drainPipe();
    stallMark      = stallCount;
    flushMark      = flushCount;
    fetchFlushMark = fetchFlushCount;
    sendInstr(first, upd);
    repeat (gap) sendInstr(nopWord, 1'b0);
    sendInstr(second, upd);
    drainPipe();
    checkValue({what, " ifIdStall cycles"}, stallCount - stallMark, stalls);
    checkValue({what, " idFlush cycles"}, flushCount - flushMark, stalls);
    checkValue({what, " ifFlush cycles"}, fetchFlushCount - fetchFlushMark, upd ? 2 : 0);
  endtask

  initial begin
    rstN     = 1'b0;
    updatePc = 1'b0;
    instr    = nopWord;
    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1;

    runPair("after reset", rWord(LLB, 1, 0, 0), 1, memWord(SW, 5, 6), 0, 1'b0);
    runPair("load use rs", memWord(LW, 3, 1), 0, rWord(ADD, 4, 3, 2), 1, 1'b0);
    runPair("load use rt", memWord(LW, 3, 1), 0, rWord(ADD, 4, 2, 3), 1, 1'b0);
    runPair("store data", memWord(LW, 3, 1), 0, memWord(SW, 3, 1), 0, 1'b0);
    runPair("store base", memWord(LW, 3, 1), 0, memWord(SW, 2, 3), 1, 1'b0);
    runPair("load r0", memWord(LW, 0, 1), 0, rWord(ADD, 4, 0, 0), 0, 1'b0);
    runPair("B after ADD", rWord(ADD, 5, 1, 2), 0, branchWord(), 1, 1'b0);
    runPair("B after XOR", rWord(XOR, 5, 1, 2), 0, branchWord(), 1, 1'b0);
    runPair("B after LW", memWord(LW, 6, 1), 0, branchWord(), 0, 1'b0);
    runPair("B after LLB", rWord(LLB, 6, 0, 0), 0, branchWord(), 0, 1'b0);
    runPair("BR base in EX", rWord(LLB, 8, 0, 0), 0, rWord(BR, 0, 8, 0), 2, 1'b0);
    runPair("BR base in MEM", rWord(LLB, 8, 0, 0), 1, rWord(BR, 0, 8, 0), 1, 1'b0);
    runPair("BR after flags", rWord(SUB, 9, 1, 2), 0, rWord(BR, 0, 10, 0), 1, 1'b0);
    runPair("BR flags and base", rWord(ADD, 7, 1, 2), 0, rWord(BR, 0, 7, 0), 2, 1'b0);
    runPair("fetch flush", nopWord, 0, rWord(PCS, 2, 0, 0), 0, 1'b1);

    // Random stream with HLT only near the end so it cannot freeze early
    for (int i = 0; i < randomCycles + finalCycles; i++) begin
      @(posedge clk);
      #1;
      if (!lastStall) instr = randomWord(i >= randomCycles);
      updatePc = (randBits(3) == 32'd0);  // About 1 in 8
    end

    // Halt holds both stalls with no bubble request
    @(posedge clk);
    #1;
    updatePc = 1'b0;
    while (lastStall && instr.rFmt.opcode != HLT) begin
      @(posedge clk);
      #1;
    end
    instr          = rWord(HLT, 0, 0, 0);
    stallMark      = stallCount;
    flushMark      = flushCount;
    repeat (haltCycles) @(posedge clk);
    checkValue("halt ifIdStall cycles", stallCount - stallMark, haltCycles);
    checkValue("halt idFlush cycles", flushCount - flushMark, 0);

    $display("All checks passed");
    $finish;
  end

  initial begin
    #(watchdogNs);
    failRun("Watchdog expired before the test sequence finished");
  end

endmodule

/* files.f */
+incdir+verif
verilog/cpuPkg.sv
verilog/instrDecoder.sv
verilog/pipeCtrlRegs.sv
verilog/hazardDetectionUnit.sv
verilog/hazardCtrlTop.sv
verif/hazardCtrlTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = hazardCtrlTb
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log
FAILMSG   = Checks failed
PASSMSG   = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASSMSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
